/* hdl/ar_issue.sv */
`timescale 1ns/1ns
`include "axi_read_consts.svh"

module ar_issue (
    input  logic                aclk,
    input  logic                rst,

    rd_req_if.issue             reqs [`NUM_PORTS],

    output axi_pkg::axi_id_t    arid,
    output mem_pkg::addr_t      araddr,
    output axi_pkg::axi_len_t   arlen,
    output axi_pkg::axi_size_t  arsize,
    output axi_pkg::axi_burst_t arburst,
    output logic                arvalid,
    input  logic                arready
);
    import mem_pkg::*;
    import axi_pkg::*;

    issue_state_t          state;
    port_idx_t             last_ptr;
    port_idx_t             grant_idx;
    logic                  grant_any;
    logic                  can_grant;
    logic                  is_line;
    logic [`NUM_PORTS-1:0] req_valid;
    logic [`NUM_PORTS-1:0] eligible;
    logic [`NUM_PORTS-1:0] accept;
    rd_kind_t              req_kind [`NUM_PORTS];
    addr_t                 req_addr [`NUM_PORTS];

    for (genvar i = 0; i < `NUM_PORTS; i++) begin : req_g
        assign req_valid[i]   = reqs[i].valid;
        assign req_kind[i]    = reqs[i].kind;
        assign req_addr[i]    = reqs[i].addr;
        assign reqs[i].accept = accept[i];
    end

    // a port whose accept is high this cycle still shows valid, so skip it.
    assign eligible  = req_valid & ~accept;
    assign can_grant = (state == issue_free) || arready;

    //////////////////////////////
    // round robin
    //////////////////////////////

    // scan from the port after last_ptr, last_ptr itself is tried last.
    always_comb begin
        int idx;
        grant_any = 1'b0;
        grant_idx = last_ptr;
        for (int off = `NUM_PORTS; off >= 1; off--) begin
            idx = (int'(last_ptr) + off) % `NUM_PORTS;
            if (eligible[idx]) begin
                grant_any = 1'b1;
                grant_idx = port_idx_t'(idx);
            end
        end
    end

    assign is_line = (req_kind[grant_idx] == rd_line);

    //////////////////////////////
    // AR channel
    //////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            state    <= issue_free;
            accept   <= '0;
            last_ptr <= port_idx_t'(`NUM_PORTS - 1);
        end else begin
            accept <= '0;
            if (can_grant && grant_any) begin
                state             <= issue_holding;
                accept[grant_idx] <= 1'b1;
                last_ptr          <= grant_idx;
            end else if (arready) begin
                state <= issue_free;
            end
        end
    end

    // the payload only moves on a grant, so it is steady while arvalid waits.
    always_ff @(posedge aclk) begin
        if (can_grant && grant_any) begin
            arid <= axi_id_t'(grant_idx);
            if (is_line) begin
                araddr <= req_addr[grant_idx] & ~addr_t'(`LINE_WORDS * 4 - 1);
                arlen  <= axi_len_t'(`LINE_LEN);
                arsize <= axi_size_t'(`SIZE_WORD);
            end else begin
                araddr <= req_addr[grant_idx];
                arlen  <= '0;
                arsize <= {1'b0, req_kind[grant_idx][1:0]};
            end
        end
    end

    assign arvalid = (state == issue_holding);
    assign arburst = axi_burst_t'(`BURST_INCR);

endmodule

/* hdl/axi_pkg.sv */
`include "axi_read_consts.svh"

package axi_pkg;

    // transaction id, carries the port number.
    typedef logic [`ID_WIDTH-1:0] axi_id_t;

    // burst length minus one.
    typedef logic [7:0] axi_len_t;

    // bytes per beat, as a power of two.
    typedef logic [2:0] axi_size_t;

    typedef logic [1:0] axi_burst_t;

endpackage

/* hdl/axi_read_consts.svh */
`ifndef AXI_READ_CONSTS_SVH
`define AXI_READ_CONSTS_SVH

// number of cache-side read ports (instruction, data).
`define NUM_PORTS 2

// bus widths.
`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define ID_WIDTH 4

// a cache line is four words, fetched as one burst of LINE_LEN + 1 beats.
`define LINE_WORDS 4
`define LINE_LEN 3

// AXI field codes.
`define BURST_INCR 1
`define SIZE_WORD 2

`endif

/* hdl/axi_read_top.sv */
`timescale 1ns/1ns
`include "axi_read_consts.svh"

module axi_read_top (
    input  logic                aclk,
    input  logic                rst,

    input  logic                inst_rd_req,
    input  mem_pkg::rd_kind_t   inst_rd_type,
    input  mem_pkg::addr_t      inst_rd_addr,
    output logic                inst_rd_rdy,
    output logic                inst_ret_valid,
    output logic                inst_ret_last,
    output mem_pkg::word_t      inst_ret_data,

    input  logic                data_rd_req,
    input  mem_pkg::rd_kind_t   data_rd_type,
    input  mem_pkg::addr_t      data_rd_addr,
    output logic                data_rd_rdy,
    output logic                data_ret_valid,
    output logic                data_ret_last,
    output mem_pkg::word_t      data_ret_data,

    output axi_pkg::axi_id_t    arid,
    output mem_pkg::addr_t      araddr,
    output axi_pkg::axi_len_t   arlen,
    output axi_pkg::axi_size_t  arsize,
    output axi_pkg::axi_burst_t arburst,
    output logic                arvalid,
    input  logic                arready,

    input  axi_pkg::axi_id_t    rid,
    input  mem_pkg::word_t      rdata,
    input  logic                rlast,
    input  logic                rvalid,
    output logic                rready
);
    import mem_pkg::*;

    logic                  rd_req_v    [`NUM_PORTS];
    rd_kind_t              rd_type_v   [`NUM_PORTS];
    addr_t                 rd_addr_v   [`NUM_PORTS];
    logic                  rd_rdy_v    [`NUM_PORTS];
    logic                  ret_valid_v [`NUM_PORTS];
    logic                  ret_last_v  [`NUM_PORTS];
    word_t                 ret_data_v  [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] beat_valid;
    word_t                 beat_data;
    logic                  beat_last;

    rd_req_if req_if [`NUM_PORTS] ();

    //////////////////////////////
    // cache side, port 0 is inst
    //////////////////////////////

    assign rd_req_v[0]  = inst_rd_req;
    assign rd_type_v[0] = inst_rd_type;
    assign rd_addr_v[0] = inst_rd_addr;
    assign rd_req_v[1]  = data_rd_req;
    assign rd_type_v[1] = data_rd_type;
    assign rd_addr_v[1] = data_rd_addr;

    assign inst_rd_rdy    = rd_rdy_v[0];
    assign inst_ret_valid = ret_valid_v[0];
    assign inst_ret_last  = ret_last_v[0];
    assign inst_ret_data  = ret_data_v[0];
    assign data_rd_rdy    = rd_rdy_v[1];
    assign data_ret_valid = ret_valid_v[1];
    assign data_ret_last  = ret_last_v[1];
    assign data_ret_data  = ret_data_v[1];

    for (genvar i = 0; i < `NUM_PORTS; i++) begin : port_g
        read_port port_i (
            .aclk       (aclk),
            .rst        (rst),
            .rd_req     (rd_req_v[i]),
            .rd_type    (rd_type_v[i]),
            .rd_addr    (rd_addr_v[i]),
            .rd_rdy     (rd_rdy_v[i]),
            .ret_valid  (ret_valid_v[i]),
            .ret_last   (ret_last_v[i]),
            .ret_data   (ret_data_v[i]),
            .beat_valid (beat_valid[i]),
            .beat_data  (beat_data),
            .beat_last  (beat_last),
            .req        (req_if[i])
        );
    end

    ar_issue ar_issue_i (
        .aclk    (aclk),
        .rst     (rst),
        .reqs    (req_if),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .arvalid (arvalid),
        .arready (arready)
    );

    r_dispatch r_dispatch_i (
        .aclk       (aclk),
        .rst        (rst),
        .rid        (rid),
        .rdata      (rdata),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .rready     (rready),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .beat_last  (beat_last)
    );

endmodule

/* hdl/mem_pkg.sv */
`include "axi_read_consts.svh"

package mem_pkg;

    typedef logic [`ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [$clog2(`NUM_PORTS)-1:0] port_idx_t;

    // the low two bits of a single-beat kind are its arsize code.
    typedef enum logic [2:0] {
        rd_byte = 3'd0,
        rd_half = 3'd1,
        rd_word = 3'd2,
        rd_line = 3'd4
    } rd_kind_t;

    typedef enum logic [1:0] {
        port_idle,
        port_pending,
        port_receiving
    } port_state_t;

    typedef enum logic {
        issue_free,
        issue_holding
    } issue_state_t;

endpackage

/* hdl/r_dispatch.sv */
`timescale 1ns/1ns
`include "axi_read_consts.svh"

module r_dispatch (
    input  logic                  aclk,
    input  logic                  rst,

    input  axi_pkg::axi_id_t      rid,
    input  mem_pkg::word_t        rdata,
    input  logic                  rlast,
    input  logic                  rvalid,
    output logic                  rready,

    output logic [`NUM_PORTS-1:0] beat_valid,
    output mem_pkg::word_t        beat_data,
    output logic                  beat_last
);
    import axi_pkg::*;

    logic take;

    assign take = rvalid && rready;

    // the ports never stall a beat, so rready stays high out of reset.
    always_ff @(posedge aclk) begin
        if (rst) begin
            rready     <= 1'b0;
            beat_valid <= '0;
        end else begin
            rready <= 1'b1;
            for (int i = 0; i < `NUM_PORTS; i++) begin
                beat_valid[i] <= take && (rid == axi_id_t'(i));
            end
        end
    end

    //////////////////////////////
    // beat payload
    //////////////////////////////

    // data and last are shared, beat_valid picks the port that owns them.
    always_ff @(posedge aclk) begin
        if (take) begin
            beat_data <= rdata;
            beat_last <= rlast;
        end
    end

endmodule

/* hdl/rd_req_if.sv */
`timescale 1ns/1ns
`include "axi_read_consts.svh"

// one port's pending read, waiting for the arbiter.
interface rd_req_if;
    import mem_pkg::*;

    logic     valid;
    rd_kind_t kind;
    addr_t    addr;
    logic     accept;

    // kind and addr hold while valid is high, accept closes the request.
    modport port (
        output valid,
        output kind,
        output addr,
        input  accept
    );

    modport issue (
        input  valid,
        input  kind,
        input  addr,
        output accept
    );

endinterface

/* hdl/read_port.sv */
`timescale 1ns/1ns
`include "axi_read_consts.svh"

module read_port (
    input  logic             aclk,
    input  logic             rst,

    input  logic             rd_req,
    input  mem_pkg::rd_kind_t rd_type,
    input  mem_pkg::addr_t   rd_addr,
    output logic             rd_rdy,
    output logic             ret_valid,
    output logic             ret_last,
    output mem_pkg::word_t   ret_data,

    input  logic             beat_valid,
    input  mem_pkg::word_t   beat_data,
    input  logic             beat_last,

    rd_req_if.port           req
);
    import mem_pkg::*;

    port_state_t state;
    rd_kind_t    kind_q;
    addr_t       addr_q;
    logic        take;

    assign take = rd_req && rd_rdy;

    assign req.valid = (state == port_pending);
    assign req.kind  = kind_q;
    assign req.addr  = addr_q;

    //////////////////////////////
    // request side
    //////////////////////////////

    // rd_rdy is a register so that it reads low all through reset.
    always_ff @(posedge aclk) begin
        if (rst) begin
            state  <= port_idle;
            rd_rdy <= 1'b0;
        end else begin
            case (state)
                port_idle: begin
                    if (take) begin
                        state  <= port_pending;
                        rd_rdy <= 1'b0;
                    end else begin
                        rd_rdy <= 1'b1;
                    end
                end
                port_pending: begin
                    if (req.accept) begin
                        state <= port_receiving;
                    end
                end
                port_receiving: begin
                    if (beat_valid && beat_last) begin
                        state <= port_idle;
                    end
                end
                default: state <= port_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            kind_q <= rd_type;
            addr_q <= rd_addr;
        end
    end

    //////////////////////////////
    // return side
    //////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
        end else begin
            ret_valid <= beat_valid && (state == port_receiving);
            ret_last  <= beat_valid && (state == port_receiving) && beat_last;
        end
    end

    always_ff @(posedge aclk) begin
        if (beat_valid) begin
            ret_data <= beat_data;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# build with Verilator, run the testbench and judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --timescale 1ns/1ns --top-module tb_axi_read \
    -f src.f -o tb_axi_read > sim.log 2>&1 &&
    ./obj_dir/tb_axi_read >> sim.log 2>&1 ||
    echo "build or simulation exited with an error" >> sim.log

cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0

/* src.f */
+incdir+hdl
hdl/axi_pkg.sv
hdl/mem_pkg.sv
hdl/rd_req_if.sv
hdl/read_port.sv
hdl/ar_issue.sv
hdl/r_dispatch.sv
hdl/axi_read_top.sv
tests/axi_read_props.sv
tests/tb_axi_read.sv

/* tests/axi_read_props.sv */
`timescale 1ns/1ns

module axi_read_props (
    input logic               aclk,
    input logic               rst,
    input logic               arvalid,
    input logic               arready,
    input axi_pkg::axi_id_t   arid,
    input mem_pkg::addr_t     araddr,
    input axi_pkg::axi_len_t  arlen,
    input axi_pkg::axi_size_t arsize,
    input logic               inst_rd_req,
    input logic               inst_rd_rdy,
    input logic               inst_ret_valid,
    input logic               inst_ret_last,
    input logic               data_rd_req,
    input logic               data_rd_rdy,
    input logic               data_ret_valid,
    input logic               data_ret_last
);
    logic inst_busy;
    logic data_busy;

    // a read is outstanding from the cycle after it is taken up to its ret_last.
    always_ff @(posedge aclk) begin
        if (rst) begin
            inst_busy <= 1'b0;
            data_busy <= 1'b0;
        end else begin
            if (inst_rd_req && inst_rd_rdy) inst_busy <= 1'b1;
            else if (inst_ret_last) inst_busy <= 1'b0;
            if (data_rd_req && data_rd_rdy) data_busy <= 1'b1;
            else if (data_ret_last) data_busy <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge aclk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable({arid, araddr, arlen, arsize}))
        else $error("AR request changed before arready");

    inst_rdy_low: assert property (@(posedge aclk) disable iff (rst) inst_busy |-> !inst_rd_rdy)
        else $error("inst_rd_rdy high while a read is outstanding");

    data_rdy_low: assert property (@(posedge aclk) disable iff (rst) data_busy |-> !data_rd_rdy)
        else $error("data_rd_rdy high while a read is outstanding");

    inst_last: assert property (@(posedge aclk) disable iff (rst) inst_ret_last |-> inst_ret_valid)
        else $error("inst_ret_last without inst_ret_valid");

    data_last: assert property (@(posedge aclk) disable iff (rst) data_ret_last |-> data_ret_valid)
        else $error("data_ret_last without data_ret_valid");

endmodule

bind axi_read_top axi_read_props props_i (.*);

/* tests/axi_read_stim.txt */
# group port kind addr first_word; group and port decimal, the rest hex
# kind 0 byte, 1 half, 2 word, 4 line; one group is requested in one cycle
0  0 2 00001000 ffffefff
1  1 2 00002004 ffffdffb
2  0 4 00003008 ffffcfff
3  1 4 0000400c ffffbfff
4  1 0 00005003 ffffafff
5  0 1 00006006 ffff9ffb
6  0 4 00007010 ffff8fef
6  1 4 00008024 ffff7fdf
7  0 2 00009000 ffff6fff
7  1 2 0000a008 ffff5ff7
8  0 4 0000b03c ffff4fcf
8  1 0 0000c001 ffff3fff
9  0 1 0000d002 ffff2fff
9  1 4 0000e048 ffff1fbf
10 0 4 10000000 efffffff
10 1 4 20000010 dfffffef
11 0 2 fffffffc 00000003
12 0 2 12345678 edcba987
12 1 1 87654322 789abcdf
13 1 2 00000000 ffffffff
14 0 0 00000101 fffffeff
14 1 2 00000200 fffffdff

/* tests/tb_axi_read.sv */
`timescale 1ns/1ns
`include "axi_read_consts.svh"

module tb_axi_read;
    import mem_pkg::*;
    import axi_pkg::*;

    logic                  aclk = 1'b0;
    logic                  rst;
    logic [`NUM_PORTS-1:0] rd_req;
    logic [`NUM_PORTS-1:0] rd_rdy;
    logic [`NUM_PORTS-1:0] ret_valid;
    logic [`NUM_PORTS-1:0] ret_last;
    rd_kind_t              rd_type [`NUM_PORTS];
    addr_t                 rd_addr [`NUM_PORTS];
    word_t                 ret_data [`NUM_PORTS];
    axi_id_t               arid;
    axi_id_t               rid;
    addr_t                 araddr;
    axi_len_t              arlen;
    axi_size_t             arsize;
    axi_burst_t            arburst;
    logic                  arvalid;
    logic                  arready;
    logic                  rvalid;
    logic                  rready;
    logic                  rlast;
    word_t                 rdata;

    // the stimulus table and the AR transactions that the slave model still has to answer.
    int          st_group[$];
    int          st_port[$];
    logic [2:0]  st_kind[$];
    logic [31:0] st_addr[$];
    logic [31:0] st_first[$];
    int          ar_ids[$];
    axi_id_t     ar_id_q[$];
    logic [31:0] ar_addr_q[$];
    int          ar_len_q[$];
    logic [2:0]  exp_kind [`NUM_PORTS];
    addr_t       exp_addr [`NUM_PORTS];
    bit          ar_due [`NUM_PORTS];
    logic [31:0] rng;

    always #50 aclk = ~aclk;

    axi_read_top dut_i (
        .inst_rd_req    (rd_req[0]),
        .inst_rd_type   (rd_type[0]),
        .inst_rd_addr   (rd_addr[0]),
        .inst_rd_rdy    (rd_rdy[0]),
        .inst_ret_valid (ret_valid[0]),
        .inst_ret_last  (ret_last[0]),
        .inst_ret_data  (ret_data[0]),
        .data_rd_req    (rd_req[1]),
        .data_rd_type   (rd_type[1]),
        .data_rd_addr   (rd_addr[1]),
        .data_rd_rdy    (rd_rdy[1]),
        .data_ret_valid (ret_valid[1]),
        .data_ret_last  (ret_last[1]),
        .data_ret_data  (ret_data[1]),
        .*
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            stop_run($sformatf("FAILED at %0t ns: %s is %h, expected %h",
                               $time, what, got, want));
        end
    endtask

    //////////////////////////////
    // request groups
    //////////////////////////////

    // requests of one group are taken in the same cycle and then every return is followed.
    task automatic run_group(input int first, input int cnt);
        int          p;
        int          waited;
        int          ar_start;
        int          got [`NUM_PORTS];
        int          stage [`NUM_PORTS];
        bit          is_line [`NUM_PORTS];
        bit          open;
        logic [31:0] want;

        waited = 0;
        open = 1'b1;
        while (open) begin
            open = 1'b0;
            for (int i = 0; i < cnt; i++) begin
                open = open || !rd_rdy[st_port[first + i]];
            end
            if (open) begin
                @(negedge aclk);
                waited++;
                if (waited > 50) stop_run("timeout: a port never raised rd_rdy");
            end
        end

        ar_start = ar_ids.size();
        for (int i = 0; i < cnt; i++) begin
            p = st_port[first + i];
            exp_kind[p] = st_kind[first + i];
            exp_addr[p] = st_addr[first + i];
            is_line[p] = (st_kind[first + i] == 3'd4);
            ar_due[p] = 1'b1;
            got[p] = 0;
            stage[p] = 2;
            rd_req[p] = 1'b1;
            rd_type[p] = rd_kind_t'(st_kind[first + i]);
            rd_addr[p] = st_addr[first + i];
        end
        @(negedge aclk);
        rd_req = '0;

        // stage 2 collects beats and stage 1 is the cycle after ret_last.
        waited = 0;
        open = 1'b1;
        while (open) begin
            open = 1'b0;
            for (int i = 0; i < cnt; i++) begin
                p = st_port[first + i];
                if (stage[p] == 1) begin
                    check(32'(rd_rdy[p]), 1, "rd_rdy after ret_last");
                    stage[p] = 0;
                end else if (stage[p] == 2) begin
                    check(32'(rd_rdy[p]), 0, "rd_rdy while a read is outstanding");
                    if (ret_valid[p]) begin
                        want = (got[p] == 0) ? st_first[first + i]
                             : ~((st_addr[first + i] & ~32'hf) + 32'(4 * got[p]));
                        check(ret_data[p], want, "ret_data");
                        check(32'(ret_last[p]), 32'(!is_line[p] || got[p] == `LINE_WORDS - 1),
                              "ret_last");
                        got[p]++;
                        if (ret_last[p]) stage[p] = 1;
                    end
                end
                open = open || (stage[p] != 0);
            end
            if (open) begin
                @(negedge aclk);
                waited++;
                if (waited > 100) stop_run("timeout: read data did not come back");
            end
        end

        // round robin puts the other port first whenever both ask at once.
        if (cnt == 2) begin
            check(32'(ar_ids.size() - ar_start), 2, "AR count of a paired request");
            check(32'(ar_ids[ar_start] != ar_ids[ar_start + 1]), 1, "arid of second grant");
            if (ar_start > 0) begin
                check(32'(ar_ids[ar_start] != ar_ids[ar_start - 1]), 1, "arid of first grant");
            end
        end
    endtask

    initial begin
        int          fd;
        int          g, p, k, n;
        logic [31:0] a, w;
        string       text;
        int          idx, cnt;

        rst = 1'b1;
        rd_req = '0;
        for (int i = 0; i < `NUM_PORTS; i++) begin
            rd_type[i] = rd_word;
            rd_addr[i] = '0;
        end
        fd = $fopen("tests/axi_read_stim.txt", "r");
        if (fd == 0) stop_run("cannot open tests/axi_read_stim.txt");
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            n = $sscanf(text, "%d %d %h %h %h", g, p, k, a, w);
            if (n == 5) begin
                st_group.push_back(g);
                st_port.push_back(p);
                st_kind.push_back(k[2:0]);
                st_addr.push_back(a);
                st_first.push_back(w);
            end
        end
        $fclose(fd);

        repeat (10) @(negedge aclk);
        rst <= 1'b0;
        @(negedge aclk);
        check(32'(rd_rdy), 32'h3, "rd_rdy after reset");
        check(32'(arvalid), 0, "arvalid after reset");
        check(32'(ret_valid), 0, "ret_valid after reset");
        check(32'(rready), 1, "rready after reset");
        check(32'(st_port.size() > 0), 1, "stimulus lines read");

        idx = 0;
        while (idx < st_port.size()) begin
            cnt = 1;
            while (idx + cnt < st_port.size() && st_group[idx + cnt] == st_group[idx]) begin
                cnt++;
            end
            run_group(idx, cnt);
            idx += cnt;
        end
        $display("Test passed");
        $finish;
    end

    //////////////////////////////
    // AXI slave memory model
    //////////////////////////////

    // each beat returns the inverse of its word address and bursts are answered in order.
    initial begin
        int p;
        int r_beat;
        bit line;

        rng = 32'ha9281d5c;
        r_beat = 0;
        arready = 1'b0;
        rvalid = 1'b0;
        rid = '0;
        rdata = '0;
        rlast = 1'b0;
        forever begin
            @(negedge aclk);
            if (!rst) begin
                if (rvalid && rready) begin
                    r_beat++;
                    if (rlast) begin
                        r_beat = 0;
                        ar_id_q.delete(0);
                        ar_addr_q.delete(0);
                        ar_len_q.delete(0);
                    end
                end
                if (!rvalid || rready) begin
                    rng = xorshift(rng);
                    rvalid = (ar_id_q.size() > 0) && (rng[5:4] != 2'b00);
                    if (rvalid) begin
                        rid = ar_id_q[0];
                        rdata = ~(ar_addr_q[0] + 32'(4 * r_beat));
                        rlast = (r_beat == ar_len_q[0]);
                    end
                end
                // arready is drawn first, so a handshake seen here happens on the next rising edge.
                rng = xorshift(rng);
                arready = rng[0];
                if (arvalid && arready) begin
                    p = int'(arid);
                    check(32'(p < `NUM_PORTS), 1, "arid names a port");
                    check(32'(ar_due[p]), 1, "AR for an outstanding request");
                    line = (exp_kind[p] == 3'd4);
                    check(araddr, line ? exp_addr[p] & ~32'hf : exp_addr[p], "araddr");
                    check(32'(arlen), line ? `LINE_LEN : 0, "arlen");
                    check(32'(arsize), line ? `SIZE_WORD : 32'(exp_kind[p][1:0]), "arsize");
                    check(32'(arburst), `BURST_INCR, "arburst");
                    ar_due[p] = 1'b0;
                    ar_ids.push_back(p);
                    ar_id_q.push_back(arid);
                    ar_addr_q.push_back(araddr & ~32'h3);
                    ar_len_q.push_back(int'(arlen));
                end
            end
        end
    end

endmodule
